/* verilog/flanger_settings.svh */
`ifndef FLANGER_SETTINGS_SVH
`define FLANGER_SETTINGS_SVH

// Delay line length in stereo samples, two memory words each
`define FLANGER_DEPTH 16
`define FLANGER_ADDR_W 5

// Sweep bounds in samples, both below FLANGER_DEPTH
`define FLANGER_DELAY_MIN 2
`define FLANGER_DELAY_MAX 5

// Processed samples per one-step delay change
`define FLANGER_SWEEP_DIV 2

// Input queue depth and initial producer credits
`define FLANGER_CREDITS 4

`endif

/* verilog/flanger_pkg.sv */
package flanger_pkg;

  // One stored stereo sample, seen as memory halves or as channels
  typedef union packed {
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } raw;
    struct packed {
      logic signed [15:0] left;
      logic signed [15:0] right;
    } chan;
  } audio_word_t;

  typedef enum logic [2:0] {
    clearing,
    idle,
    read_hi,
    read_lo,
    write_hi,
    write_lo,
    mix
  } ctrl_state_t;

endpackage

/* verilog/sample_credit_fifo.sv */
`timescale 1ns/10ps
`include "flanger_settings.svh"

module sample_credit_fifo (
  input  logic                    clk,
  input  logic                    n_rst,
  input  logic                    sample_valid,
  input  flanger_pkg::audio_word_t sample_in,
  input  logic                    pop,
  output logic                    q_empty,
  output flanger_pkg::audio_word_t q_data,
  output logic                    credit_return
);
  import flanger_pkg::*;

  localparam int depth = `FLANGER_CREDITS;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  audio_word_t      entries [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;

  always_ff @(posedge clk) begin
    if (sample_valid) begin
      entries[wr_ptr] <= sample_in;
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;
      if (sample_valid) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({sample_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign q_empty = (count == '0);
  assign q_data  = entries[rd_ptr];

  // Producer spent a credit it did not have
  a_no_overflow: assert property (@(posedge clk) disable iff (!n_rst)
    sample_valid |-> (count != cnt_w'(depth)));

  a_no_underflow: assert property (@(posedge clk) disable iff (!n_rst)
    pop |-> !q_empty);

endmodule

/* verilog/delay_sweep_lfo.sv */
`timescale 1ns/10ps
`include "flanger_settings.svh"

module delay_sweep_lfo (
  input  logic                       clk,
  input  logic                       n_rst,
  input  logic                       advance,
  output logic [`FLANGER_ADDR_W-1:0] delay_samples
);

  localparam int div_w = $clog2(`FLANGER_SWEEP_DIV + 1);
  localparam logic [`FLANGER_ADDR_W-1:0] delay_min = `FLANGER_ADDR_W'(`FLANGER_DELAY_MIN);
  localparam logic [`FLANGER_ADDR_W-1:0] delay_max = `FLANGER_ADDR_W'(`FLANGER_DELAY_MAX);

  logic [div_w-1:0] div_cnt;
  logic             going_up;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      div_cnt       <= '0;
      going_up      <= 1'b1;
      delay_samples <= delay_min;
    end else if (advance) begin
      if (div_cnt == div_w'(`FLANGER_SWEEP_DIV - 1)) begin
        div_cnt <= '0;
        // Step toward the bound, turn around on arrival
        if (going_up) begin
          delay_samples <= delay_samples + 1'b1;
          if (delay_samples + 1'b1 == delay_max) going_up <= 1'b0;
        end else begin
          delay_samples <= delay_samples - 1'b1;
          if (delay_samples - 1'b1 == delay_min) going_up <= 1'b1;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  a_delay_in_range: assert property (@(posedge clk) disable iff (!n_rst)
    (delay_samples >= delay_min) && (delay_samples <= delay_max));

endmodule

/* verilog/delay_line_sram.sv */
`timescale 1ns/10ps
`include "flanger_settings.svh"

module delay_line_sram (
  input  logic                       clk,
  input  logic [`FLANGER_ADDR_W-1:0] mem_addr,
  input  logic [15:0]                mem_wdata,
  input  logic                       mem_we,
  input  logic                       mem_re,
  output logic [15:0]                mem_rdata
);

  localparam int words = 2 * `FLANGER_DEPTH;

  logic [15:0] mem [words];

  // Single port, read data lands one cycle after the request
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    if (mem_re) begin
      mem_rdata <= mem[mem_addr];
    end
  end

  a_one_access: assert property (@(posedge clk)
    !(mem_re && mem_we));

endmodule

/* verilog/flanger_ctrl.sv */
`timescale 1ns/10ps
`include "flanger_settings.svh"

module flanger_ctrl (
  input  logic                       clk,
  input  logic                       n_rst,
  input  logic                       q_empty,
  input  flanger_pkg::audio_word_t   q_data,
  output logic                       pop,
  input  logic [`FLANGER_ADDR_W-1:0] delay_samples,
  output logic                       advance,
  output logic [`FLANGER_ADDR_W-1:0] mem_addr,
  output logic [15:0]                mem_wdata,
  output logic                       mem_we,
  output logic                       mem_re,
  input  logic [15:0]                mem_rdata,
  output logic                       mix_valid,
  output flanger_pkg::audio_word_t   dry_sample,
  output flanger_pkg::audio_word_t   wet_sample
);
  import flanger_pkg::*;

  localparam int words  = 2 * `FLANGER_DEPTH;
  localparam int slot_w = `FLANGER_ADDR_W - 1;

  ctrl_state_t                state;
  ctrl_state_t                next_state;
  logic [`FLANGER_ADDR_W-1:0] clr_cnt;
  logic [`FLANGER_ADDR_W-1:0] seen;
  logic [slot_w-1:0]          wr_slot;
  logic [slot_w-1:0]          rd_slot;
  logic                       hist_ok;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state   <= clearing;
      clr_cnt <= '0;
      wr_slot <= '0;
      seen    <= '0;
    end else begin
      state <= next_state;
      if (state == clearing) clr_cnt <= clr_cnt + 1'b1;
      if (state == mix) begin
        wr_slot <= wr_slot + 1'b1;
        // Saturate once history covers any delay
        if (seen != `FLANGER_ADDR_W'(`FLANGER_DEPTH)) seen <= seen + 1'b1;
      end
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      clearing: if (clr_cnt == `FLANGER_ADDR_W'(words - 1)) next_state = idle;
      idle:     if (!q_empty) next_state = read_hi;
      read_hi:  next_state = read_lo;
      read_lo:  next_state = write_hi;
      write_hi: next_state = write_lo;
      write_lo: next_state = mix;
      mix:      next_state = idle;
      default:  next_state = clearing;
    endcase
  end

  // Slot index wraps naturally since the depth is a power of two
  assign rd_slot = wr_slot - delay_samples[slot_w-1:0];
  assign hist_ok = (seen >= delay_samples);

  assign pop       = (state == idle) && !q_empty;
  assign mem_re    = (state == read_hi) || (state == read_lo);
  assign mem_we    = (state == clearing) || (state == write_hi) || (state == write_lo);
  assign advance   = (state == mix);
  assign mix_valid = (state == mix);

  always_comb begin
    mem_addr  = '0;
    mem_wdata = '0;
    case (state)
      clearing: mem_addr = clr_cnt;
      read_hi:  mem_addr = {rd_slot, 1'b0};
      read_lo:  mem_addr = {rd_slot, 1'b1};
      write_hi: begin
        mem_addr  = {wr_slot, 1'b0};
        mem_wdata = dry_sample.raw.hi;
      end
      write_lo: begin
        mem_addr  = {wr_slot, 1'b1};
        mem_wdata = dry_sample.raw.lo;
      end
      default: mem_addr = '0;
    endcase
  end

  // High half returns during read_lo, low half during write_hi
  always_ff @(posedge clk) begin
    if (pop) dry_sample <= q_data;
    if (state == read_lo) wet_sample.raw.hi <= hist_ok ? mem_rdata : '0;
    if (state == write_hi) wet_sample.raw.lo <= hist_ok ? mem_rdata : '0;
  end

endmodule

/* verilog/flanger_mixer.sv */
`timescale 1ns/10ps

module flanger_mixer (
  input  logic                     clk,
  input  logic                     n_rst,
  input  logic                     flanger_en,
  input  logic                     mix_valid,
  input  flanger_pkg::audio_word_t dry_sample,
  input  flanger_pkg::audio_word_t wet_sample,
  output logic                     out_valid,
  output flanger_pkg::audio_word_t out_sample
);
  import flanger_pkg::*;

  audio_word_t mixed;

  // Dry plus half wet, clamped to 16 bits
  function automatic logic [15:0] sat_mix(input logic [15:0] dry, input logic [15:0] wet);
    logic [16:0] sum;
    sum = {dry[15], dry} + {wet[15], wet[15], wet[15:1]};
    if (sum[16] != sum[15]) begin
      return sum[16] ? 16'h8000 : 16'h7fff;
    end
    return sum[15:0];
  endfunction

  always_comb begin
    if (flanger_en) begin
      mixed.chan.left  = sat_mix(dry_sample.chan.left, wet_sample.chan.left);
      mixed.chan.right = sat_mix(dry_sample.chan.right, wet_sample.chan.right);
    end else begin
      mixed = dry_sample;
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= mix_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mix_valid) out_sample <= mixed;
  end

endmodule

/* verilog/flanger_top.sv */
`timescale 1ns/10ps
`include "flanger_settings.svh"

module flanger_top (
  input  logic                     clk,
  input  logic                     n_rst,
  input  logic                     flanger_en,
  input  logic                     sample_valid,
  input  flanger_pkg::audio_word_t sample_in,
  output logic                     credit_return,
  output logic                     out_valid,
  output flanger_pkg::audio_word_t out_sample
);
  import flanger_pkg::*;

  logic                       q_empty;
  audio_word_t                q_data;
  logic                       pop;
  logic [`FLANGER_ADDR_W-1:0] delay_samples;
  logic                       advance;
  logic [`FLANGER_ADDR_W-1:0] mem_addr;
  logic [15:0]                mem_wdata;
  logic                       mem_we;
  logic                       mem_re;
  logic [15:0]                mem_rdata;
  logic                       mix_valid;
  audio_word_t                dry_sample;
  audio_word_t                wet_sample;

  sample_credit_fifo u_fifo (
    .clk           (clk),
    .n_rst         (n_rst),
    .sample_valid  (sample_valid),
    .sample_in     (sample_in),
    .pop           (pop),
    .q_empty       (q_empty),
    .q_data        (q_data),
    .credit_return (credit_return)
  );

  delay_sweep_lfo u_lfo (
    .clk           (clk),
    .n_rst         (n_rst),
    .advance       (advance),
    .delay_samples (delay_samples)
  );

  delay_line_sram u_sram (
    .clk       (clk),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we),
    .mem_re    (mem_re),
    .mem_rdata (mem_rdata)
  );

  flanger_ctrl u_ctrl (
    .clk           (clk),
    .n_rst         (n_rst),
    .q_empty       (q_empty),
    .q_data        (q_data),
    .pop           (pop),
    .delay_samples (delay_samples),
    .advance       (advance),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_we        (mem_we),
    .mem_re        (mem_re),
    .mem_rdata     (mem_rdata),
    .mix_valid     (mix_valid),
    .dry_sample    (dry_sample),
    .wet_sample    (wet_sample)
  );

  flanger_mixer u_mixer (
    .clk        (clk),
    .n_rst      (n_rst),
    .flanger_en (flanger_en),
    .mix_valid  (mix_valid),
    .dry_sample (dry_sample),
    .wet_sample (wet_sample),
    .out_valid  (out_valid),
    .out_sample (out_sample)
  );

endmodule

/* tb/flanger_tb.sv */
`timescale 1ns/10ps
`include "flanger_settings.svh"

module flanger_tb;
  import flanger_pkg::*;

  localparam int num_samples   = 24;
  localparam int fields        = 5;
  localparam int wait_limit    = 200;
  localparam int credit_to_out = 5;

  logic        clk;
  logic        n_rst;
  logic        flanger_en;
  logic        sample_valid;
  audio_word_t sample_in;
  logic        credit_return;
  logic        out_valid;
  audio_word_t out_sample;

  // Per sample: en, left in, right in, expected left, expected right
  logic [15:0] vectors [fields*num_samples];

  int errors;
  int timeouts;
  int credits;
  int cycle_cnt = 0;
  int valid_pulses = 0;
  int credit_cycles [$];

  flanger_top DUT (
    .clk           (clk),
    .n_rst         (n_rst),
    .flanger_en    (flanger_en),
    .sample_valid  (sample_valid),
    .sample_in     (sample_in),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out_sample    (out_sample)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Sees pre-edge values, so the stored cycle is the one the pulse rose in
  always @(posedge clk) begin
    if (n_rst && credit_return) credit_cycles.push_back(cycle_cnt);
    if (n_rst && out_valid) valid_pulses++;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  // One producer cycle, picking up a returned credit
  task automatic tick_and_collect_credit();
    @(posedge clk);
    #1;
    if (credit_return) credits++;
  endtask

  task automatic send_samples();
    int   gap;
    int   waited;
    logic stalled;
    stalled = 1'b0;
    for (int k = 0; k < num_samples && !stalled; k++) begin
      gap = $urandom_range(7, 0);
      repeat (gap) tick_and_collect_credit();
      waited = 0;
      while (credits == 0 && waited < wait_limit) begin
        tick_and_collect_credit();
        waited++;
      end
      if (credits == 0) begin
        $display("Producer timed out waiting for a credit before sample %0d", k);
        timeouts++;
        stalled = 1'b1;
      end else begin
        sample_valid     = 1'b1;
        sample_in.raw.hi = vectors[fields*k+1];
        sample_in.raw.lo = vectors[fields*k+2];
        credits--;
        tick_and_collect_credit();
        sample_valid = 1'b0;
      end
    end
  endtask

  task automatic collect_outputs();
    int   waited;
    logic stalled;
    stalled = 1'b0;
    for (int k = 0; k < num_samples && !stalled; k++) begin
      waited = 0;
      @(posedge clk);
      #1;
      while (!out_valid && waited < wait_limit) begin
        @(posedge clk);
        #1;
        waited++;
      end
      if (!out_valid) begin
        $display("Checker timed out waiting for the output of sample %0d", k);
        timeouts++;
        stalled = 1'b1;
      end else begin
        check_value($sformatf("sample %0d left", k), 32'(vectors[fields*k+3]),
                    32'(out_sample.raw.hi));
        check_value($sformatf("sample %0d right", k), 32'(vectors[fields*k+4]),
                    32'(out_sample.raw.lo));
        if (k < credit_cycles.size()) begin
          check_value($sformatf("sample %0d credit to output cycles", k),
                      32'(credit_to_out), 32'(cycle_cnt - credit_cycles[k]));
        end else begin
          $display("Output of sample %0d arrived without a returned credit", k);
          errors++;
        end
        // Next sample cannot reach its mix cycle before this point
        if (k + 1 < num_samples) flanger_en = vectors[fields*(k+1)][0];
      end
    end
  endtask

  initial begin
    n_rst        = 1'b0;
    flanger_en   = 1'b0;
    sample_valid = 1'b0;
    sample_in    = '0;
    errors       = 0;
    timeouts     = 0;
    credits      = `FLANGER_CREDITS;
    void'($urandom(92002));
    $readmemh("tb/flanger_input.txt", vectors);
    flanger_en = vectors[0][0];
    repeat (8) @(posedge clk);
    #1;
    n_rst = 1'b1;
    fork
      send_samples();
      collect_outputs();
    join
    // Room for any stray pulse before the totals
    repeat (20) @(posedge clk);
    check_value("credit pulses", 32'(num_samples), 32'(credit_cycles.size()));
    check_value("out_valid pulses", 32'(num_samples), 32'(valid_pulses));
    $display("Finished with %0d mismatches and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* tb/flanger_input.txt */
// en left_in right_in exp_left exp_right, all hex
// one stereo sample per line, in send order
1 0100 0200 0100 0200
1 0300 ff00 0300 ff00
1 0500 fe00 0500 fe00
1 0700 0400 0780 0500
1 0040 0010 00c0 0110
1 1000 2000 1180 1f80
1 0000 0000 0180 ff80
1 0020 fff0 02a0 fef0
1 0200 0300 0220 0308
1 f000 0100 f800 1100
1 0001 0003 0011 fffb
1 4000 c000 4100 c180
0 2222 1111 2222 1111
0 0600 fa00 0600 fa00
0 7fff 8000 7fff 8000
0 0042 ffbe 0042 ffbe
1 7000 9000 7fff 9888
1 6000 a000 6300 9d00
1 0100 0000 0400 fd00
1 0010 0010 400f c010
1 6000 a000 7fff 8000
1 5000 0100 7fff d100
1 8000 7fff 8008 7fff
1 9000 7000 c000 4000

/* list.f */
+incdir+verilog
verilog/flanger_pkg.sv
verilog/sample_credit_fifo.sv
verilog/delay_sweep_lfo.sv
verilog/delay_line_sram.sv
verilog/flanger_ctrl.sv
verilog/flanger_mixer.sv
verilog/flanger_top.sv
tb/flanger_tb.sv

/* Makefile */
TOP = flanger_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^test passed$$" sim.log || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir sim.log
